// File: common/reg_access_cfg.svh
// Register access stage configuration
// Widths, fixed register numbers and operand kind codes

`ifndef REG_ACCESS_CFG_SVH
`define REG_ACCESS_CFG_SVH

// Datapath widths
`define RA_DATA_W   32
`define RA_NUM_GPR  8
`define RA_SEG_W    16
`define RA_OP_W     3

// x86 register numbering
`define RA_ESP_NUM  4
`define RA_ESI_NUM  6
`define RA_EDI_NUM  7

// Operand kind that takes its register from ModR/M rm
`define RA_OP_MODRM 4

`endif

// File: common/reg_access_pkg.sv
// Register access stage types
// Register numbers, sized register words, operand sizes and stack ops

package reg_access_pkg;

    `include "reg_access_cfg.svh"

    typedef logic [2:0] gpr_num_t;

    // Whole register or its lanes for sized merges
    typedef union packed {
        logic [`RA_DATA_W-1:0] dword;
        struct packed {
            logic [15:0] upper;
            logic [7:0]  b1;
            logic [7:0]  b0;
        } lanes;
    } gpr_word_u;

    // Zero is not a legal size
    typedef enum logic [2:0] {
        SIZE_BYTE  = 3'd1,
        SIZE_WORD  = 3'd2,
        SIZE_DWORD = 3'd3
    } op_size_t;

    typedef struct packed {
        logic pop;
        logic push;
    } stack_op_t;

    typedef logic [`RA_NUM_GPR-1:0][`RA_DATA_W-1:0] gpr_array_t;

    // Push and MOVS step of 1, 2 or 4 bytes
    function automatic logic [`RA_DATA_W-1:0] size_step(op_size_t size);
        case (size)
            SIZE_WORD:  return `RA_DATA_W'(2);
            SIZE_DWORD: return `RA_DATA_W'(4);
            default:    return `RA_DATA_W'(1);
        endcase
    endfunction

    // Pops never move by one byte
    function automatic logic [`RA_DATA_W-1:0] pop_step(op_size_t size);
        return (size == SIZE_WORD) ? `RA_DATA_W'(2) : `RA_DATA_W'(4);
    endfunction

endpackage

// File: common/wb_if.sv
// Register writeback bus from the writeback stage
// Sized write of one general register tagged when a stack instruction made it

`include "reg_access_cfg.svh"

interface wb_if;
    import reg_access_pkg::*;

    gpr_num_t              reg_number;
    logic                  en;
    op_size_t              size;
    logic [`RA_DATA_W-1:0] data;
    // Set for writebacks produced by push/pop
    logic                  stack;

    modport regfile (
        input reg_number, en, size, data, stack
    );

    // Stack pointer tracker watches for direct ESP writes
    modport monitor (
        input reg_number, en, size, data, stack
    );

endinterface

// File: hdl/operand_select.sv
// Operand register selection
// Resolves each operand's register number from ModR/M rm or from decode
// and reads the full register value

`include "reg_access_cfg.svh"

module operand_select (
    input  logic [`RA_OP_W-1:0]       d_op0,
    input  logic [`RA_OP_W-1:0]       d_op1,
    input  reg_access_pkg::gpr_num_t  d_op0_reg,
    input  reg_access_pkg::gpr_num_t  d_op1_reg,
    input  logic [7:0]                d_modrm,
    input  reg_access_pkg::gpr_array_t regs,
    output reg_access_pkg::gpr_num_t  r_op0_reg,
    output reg_access_pkg::gpr_num_t  r_op1_reg,
    output logic [`RA_DATA_W-1:0]     r_op0_value,
    output logic [`RA_DATA_W-1:0]     r_op1_value
);
    import reg_access_pkg::*;

    gpr_num_t op0_num;
    gpr_num_t op1_num;

    // Kind 4 means the register sits in the rm field
    function automatic gpr_num_t pick_reg(
        logic [`RA_OP_W-1:0] kind,
        gpr_num_t            decoded,
        logic [7:0]          modrm
    );
        if (kind == `RA_OP_W'(`RA_OP_MODRM)) begin
            return modrm[2:0];
        end
        return decoded;
    endfunction

    assign op0_num = pick_reg(d_op0, d_op0_reg, d_modrm);
    assign op1_num = pick_reg(d_op1, d_op1_reg, d_modrm);

    assign r_op0_reg = op0_num;
    assign r_op1_reg = op1_num;

    // Consumers slice the whole dword by size
    assign r_op0_value = regs[op0_num];
    assign r_op1_value = regs[op1_num];

endmodule

// File: hdl/register_access_top.sv
// Register access stage
// Operand register reads, MOVS index updates and stack address generation
// Combinational from decode to address generation

`include "reg_access_cfg.svh"

module register_access_top (
    input  logic                     clk,
    input  logic                     rst,

    // Decode side
    input  logic                     d_valid,
    output logic                     d_ready,
    input  reg_access_pkg::op_size_t d_size,
    input  logic [`RA_OP_W-1:0]      d_op0,
    input  logic [`RA_OP_W-1:0]      d_op1,
    input  reg_access_pkg::gpr_num_t d_op0_reg,
    input  reg_access_pkg::gpr_num_t d_op1_reg,
    input  logic [7:0]               d_modrm,
    input  reg_access_pkg::stack_op_t d_stack_op,
    input  logic                     d_movs,
    input  logic                     flag_df,
    input  logic [`RA_SEG_W-1:0]     ss,

    // Register writeback
    input  reg_access_pkg::gpr_num_t wb_reg_number,
    input  logic                     wb_reg_en,
    input  reg_access_pkg::op_size_t wb_reg_size,
    input  logic [`RA_DATA_W-1:0]    wb_reg_data,
    input  logic                     wb_stack,

    // Stack commit
    input  logic                     wb_stack_en,
    input  reg_access_pkg::op_size_t wb_stack_size,
    input  reg_access_pkg::stack_op_t wb_stack_op,

    // Address generation side
    output logic                     r_valid,
    input  logic                     r_ready,
    output reg_access_pkg::gpr_num_t r_op0_reg,
    output reg_access_pkg::gpr_num_t r_op1_reg,
    output logic [`RA_DATA_W-1:0]    r_op0_value,
    output logic [`RA_DATA_W-1:0]    r_op1_value,
    output logic [`RA_DATA_W-1:0]    r_stack_address,
    output logic [`RA_DATA_W-1:0]    r_esp
);
    import reg_access_pkg::*;

    logic       accept;
    gpr_array_t regs;

    wb_if u_wb ();

    // No pipeline register in this stage
    assign r_valid = d_valid;
    assign d_ready = r_ready;
    assign accept  = d_valid && r_ready;

    assign u_wb.reg_number = wb_reg_number;
    assign u_wb.en         = wb_reg_en;
    assign u_wb.size       = wb_reg_size;
    assign u_wb.data       = wb_reg_data;
    assign u_wb.stack      = wb_stack;

    // Committed ESP straight out of the register file
    assign r_esp = regs[`RA_ESP_NUM];

    gpr_file u_gpr_file (
        .clk           (clk),
        .rst           (rst),
        .wb            (u_wb.regfile),
        .accept        (accept),
        .d_movs        (d_movs),
        .flag_df       (flag_df),
        .d_size        (d_size),
        .wb_stack_en   (wb_stack_en),
        .wb_stack_size (wb_stack_size),
        .wb_stack_op   (wb_stack_op),
        .regs          (regs)
    );

    operand_select u_operand_select (
        .d_op0       (d_op0),
        .d_op1       (d_op1),
        .d_op0_reg   (d_op0_reg),
        .d_op1_reg   (d_op1_reg),
        .d_modrm     (d_modrm),
        .regs        (regs),
        .r_op0_reg   (r_op0_reg),
        .r_op1_reg   (r_op1_reg),
        .r_op0_value (r_op0_value),
        .r_op1_value (r_op1_value)
    );

    stack_pointer_tracker u_stack_pointer_tracker (
        .clk             (clk),
        .rst             (rst),
        .wb              (u_wb.monitor),
        .accept          (accept),
        .d_stack_op      (d_stack_op),
        .d_size          (d_size),
        .ss              (ss),
        .r_stack_address (r_stack_address)
    );

endmodule

// File: regfile/gpr_file.sv
// General purpose register file
// Eight 32-bit registers with sized writeback, MOVS stepping of ESI/EDI
// and the committed ESP update from the stack commit port

`include "reg_access_cfg.svh"

module gpr_file (
    input  logic                      clk,
    input  logic                      rst,
    wb_if.regfile                     wb,
    input  logic                      accept,
    input  logic                      d_movs,
    input  logic                      flag_df,
    input  reg_access_pkg::op_size_t  d_size,
    input  logic                      wb_stack_en,
    input  reg_access_pkg::op_size_t  wb_stack_size,
    input  reg_access_pkg::stack_op_t wb_stack_op,
    output reg_access_pkg::gpr_array_t regs
);
    import reg_access_pkg::*;

    gpr_word_u             gpr_q [`RA_NUM_GPR];
    gpr_word_u             wb_merged;
    logic                  movs_en;
    logic [`RA_DATA_W-1:0] movs_step;
    logic [`RA_DATA_W-1:0] esi_next;
    logic [`RA_DATA_W-1:0] edi_next;
    logic [`RA_DATA_W-1:0] esp_q;
    logic [`RA_DATA_W-1:0] esp_commit;

    // Sized writeback keeps the untouched lanes of the old value
    always_comb begin
        wb_merged = gpr_q[wb.reg_number];
        case (wb.size)
            SIZE_BYTE: begin
                wb_merged.lanes.b0 = wb.data[7:0];
            end
            SIZE_WORD: begin
                wb_merged.lanes.b1 = wb.data[15:8];
                wb_merged.lanes.b0 = wb.data[7:0];
            end
            default: begin
                wb_merged.dword = wb.data;
            end
        endcase
    end

    // Direction flag set makes the string move indexes count down
    assign movs_en   = accept && d_movs;
    assign movs_step = size_step(d_size);
    assign esi_next  = flag_df ? gpr_q[`RA_ESI_NUM].dword - movs_step
                               : gpr_q[`RA_ESI_NUM].dword + movs_step;
    assign edi_next  = flag_df ? gpr_q[`RA_EDI_NUM].dword - movs_step
                               : gpr_q[`RA_EDI_NUM].dword + movs_step;

    // Committed ESP moves only when the stack op retires
    assign esp_q      = gpr_q[`RA_ESP_NUM].dword;
    assign esp_commit = wb_stack_op.pop ? esp_q + pop_step(wb_stack_size)
                                        : esp_q - size_step(wb_stack_size);

    // Stack commit overrides MOVS which overrides writeback
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `RA_NUM_GPR; i++) begin
                gpr_q[i] <= '0;
            end
        end else begin
            if (wb.en) begin
                gpr_q[wb.reg_number] <= wb_merged;
            end
            if (movs_en) begin
                gpr_q[`RA_ESI_NUM].dword <= esi_next;
                gpr_q[`RA_EDI_NUM].dword <= edi_next;
            end
            if (wb_stack_en) begin
                gpr_q[`RA_ESP_NUM].dword <= esp_commit;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `RA_NUM_GPR; i++) begin
            regs[i] = gpr_q[i].dword;
        end
    end

    // Decode must never hand over a sizeless string move
    a_movs_size_legal: assert property (
        @(posedge clk) disable iff (rst)
        movs_en |-> (d_size inside {SIZE_BYTE, SIZE_WORD, SIZE_DWORD})
    );

    // A retiring stack op is either a push or a pop
    a_stack_commit_onehot: assert property (
        @(posedge clk) disable iff (rst)
        wb_stack_en |-> !(wb_stack_op.pop && wb_stack_op.push)
    );

endmodule

// File: sim/tb_vectors.svh
// Register access testbench vectors
// Row type holding the applied inputs and the expected outputs of one cycle

`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

typedef struct {
    // Decode side
    logic                  d_valid;
    logic                  r_ready;
    op_size_t              d_size;
    logic [`RA_OP_W-1:0]   d_op0;
    logic [`RA_OP_W-1:0]   d_op1;
    gpr_num_t              d_op0_reg;
    gpr_num_t              d_op1_reg;
    logic [7:0]            d_modrm;
    stack_op_t             d_stack_op;
    logic                  d_movs;
    logic                  flag_df;
    logic [`RA_SEG_W-1:0]  ss;
    // Writeback and stack commit
    gpr_num_t              wb_reg_number;
    logic                  wb_reg_en;
    op_size_t              wb_reg_size;
    logic [`RA_DATA_W-1:0] wb_reg_data;
    logic                  wb_stack;
    logic                  wb_stack_en;
    op_size_t              wb_stack_size;
    stack_op_t             wb_stack_op;
    // Expected responses
    gpr_num_t              exp_op0_reg;
    gpr_num_t              exp_op1_reg;
    logic [`RA_DATA_W-1:0] exp_op0_value;
    logic [`RA_DATA_W-1:0] exp_op1_value;
    logic [`RA_DATA_W-1:0] exp_stack_address;
    logic [`RA_DATA_W-1:0] exp_esp;
    logic                  exp_d_ready;
    logic                  exp_r_valid;
} vec_row_t;

vec_row_t vectors[$];

`endif

// File: sim/tb_register_access.sv
// Register access stage testbench
// Reference model builds a vector table, which is applied one row per cycle

`include "reg_access_cfg.svh"

module tb_register_access;
    import reg_access_pkg::*;

    `include "tb_vectors.svh"

    localparam int CHECK_DELAY = 18;
    localparam int RESET_CYCLES = 16;

    logic clk = 1'b0;
    logic rst;
    logic d_valid, d_ready, r_valid, r_ready;
    op_size_t d_size;
    logic [`RA_OP_W-1:0] d_op0, d_op1;
    gpr_num_t d_op0_reg, d_op1_reg;
    logic [7:0] d_modrm;
    stack_op_t d_stack_op;
    logic d_movs, flag_df;
    logic [`RA_SEG_W-1:0] ss;
    gpr_num_t wb_reg_number;
    logic wb_reg_en;
    op_size_t wb_reg_size;
    logic [`RA_DATA_W-1:0] wb_reg_data;
    logic wb_stack, wb_stack_en;
    op_size_t wb_stack_size;
    stack_op_t wb_stack_op;
    gpr_num_t r_op0_reg, r_op1_reg;
    logic [`RA_DATA_W-1:0] r_op0_value, r_op1_value, r_stack_address, r_esp;

    // Reference model state
    logic [`RA_DATA_W-1:0] model_regs [`RA_NUM_GPR];
    logic [`RA_DATA_W-1:0] model_local_esp;
    integer seed = 91;
    int cycle_count = 0;
    int timeout_limit;

    register_access_top u_dut (.*);

    always #20 clk = ~clk;

    // Byte counts for push, MOVS and pop
    function automatic logic [`RA_DATA_W-1:0] step_bytes(op_size_t size, logic for_pop);
        if (for_pop) begin
            return (size == SIZE_WORD) ? 32'd2 : 32'd4;
        end
        case (size)
            SIZE_BYTE: return 32'd1;
            SIZE_WORD: return 32'd2;
            default:   return 32'd4;
        endcase
    endfunction

    function automatic logic [`RA_DATA_W-1:0] merge_sized(logic [`RA_DATA_W-1:0] old,
                                                         logic [`RA_DATA_W-1:0] data,
                                                         op_size_t size);
        case (size)
            SIZE_BYTE: return {old[31:8], data[7:0]};
            SIZE_WORD: return {old[31:16], data[15:0]};
            default:   return data;
        endcase
    endfunction

    task automatic base_row(output vec_row_t r);
        r.d_valid       = 1'b1;
        r.r_ready       = 1'b1;
        r.d_size        = SIZE_DWORD;
        r.d_op0         = '0;
        r.d_op1         = '0;
        r.d_op0_reg     = gpr_num_t'(0);
        r.d_op1_reg     = gpr_num_t'(1);
        r.d_modrm       = '0;
        r.d_stack_op    = '0;
        r.d_movs        = 1'b0;
        r.flag_df       = 1'b0;
        r.ss            = 16'h1234;
        r.wb_reg_number = gpr_num_t'(0);
        r.wb_reg_en     = 1'b0;
        r.wb_reg_size   = SIZE_DWORD;
        r.wb_reg_data   = '0;
        r.wb_stack      = 1'b0;
        r.wb_stack_en   = 1'b0;
        r.wb_stack_size = SIZE_DWORD;
        r.wb_stack_op   = '0;
    endtask

    // Expected outputs come from the model state before it steps one cycle
    task automatic add_row(input vec_row_t r);
        logic [`RA_DATA_W-1:0] next_regs [`RA_NUM_GPR];
        logic [`RA_DATA_W-1:0] base;
        logic [`RA_DATA_W-1:0] movs_step;
        logic                  accepted;
        gpr_num_t              n0;
        gpr_num_t              n1;
        accepted = r.d_valid && r.r_ready;
        n0 = (r.d_op0 == `RA_OP_MODRM) ? r.d_modrm[2:0] : r.d_op0_reg;
        n1 = (r.d_op1 == `RA_OP_MODRM) ? r.d_modrm[2:0] : r.d_op1_reg;
        r.exp_op0_reg   = n0;
        r.exp_op1_reg   = n1;
        r.exp_op0_value = model_regs[n0];
        r.exp_op1_value = model_regs[n1];
        r.exp_esp       = model_regs[`RA_ESP_NUM];
        r.exp_d_ready   = r.r_ready;
        r.exp_r_valid   = r.d_valid;
        base = {r.ss, 16'h0000};
        r.exp_stack_address = r.d_stack_op.pop ? base + model_local_esp
                              : base + model_local_esp - step_bytes(r.d_size, 1'b0);
        next_regs = model_regs;
        if (r.wb_reg_en) begin
            next_regs[r.wb_reg_number] = merge_sized(model_regs[r.wb_reg_number],
                                                     r.wb_reg_data, r.wb_reg_size);
        end
        if (accepted && r.d_movs) begin
            movs_step = step_bytes(r.d_size, 1'b0);
            next_regs[`RA_ESI_NUM] = r.flag_df ? model_regs[`RA_ESI_NUM] - movs_step
                                               : model_regs[`RA_ESI_NUM] + movs_step;
            next_regs[`RA_EDI_NUM] = r.flag_df ? model_regs[`RA_EDI_NUM] - movs_step
                                               : model_regs[`RA_EDI_NUM] + movs_step;
        end
        if (r.wb_stack_en) begin
            next_regs[`RA_ESP_NUM] = r.wb_stack_op.pop
                ? model_regs[`RA_ESP_NUM] + step_bytes(r.wb_stack_size, 1'b1)
                : model_regs[`RA_ESP_NUM] - step_bytes(r.wb_stack_size, 1'b0);
        end
        // Direct ESP write wins over speculative moves
        if (r.wb_reg_en && !r.wb_stack && r.wb_reg_number == `RA_ESP_NUM) begin
            model_local_esp = r.wb_reg_data;
        end else if (accepted && r.d_stack_op.pop) begin
            model_local_esp = model_local_esp + step_bytes(r.d_size, 1'b1);
        end else if (accepted && r.d_stack_op.push) begin
            model_local_esp = model_local_esp - step_bytes(r.d_size, 1'b0);
        end
        model_regs = next_regs;
        vectors.push_back(r);
    endtask

    task automatic fill_table();
        vec_row_t    r;
        gpr_num_t    prev;
        logic [31:0] rnd;
        for (int i = 0; i < `RA_NUM_GPR; i++) begin
            model_regs[i] = '0;
        end
        model_local_esp = '0;
        // Each register written whole and read back on the next row
        for (int i = 0; i < `RA_NUM_GPR; i++) begin
            base_row(r);
            r.wb_reg_en     = 1'b1;
            r.wb_reg_number = gpr_num_t'(i);
            r.wb_reg_data   = $random(seed);
            r.d_op0_reg     = gpr_num_t'(i + 7);
            r.d_op1_reg     = gpr_num_t'(i);
            add_row(r);
        end
        // Sized merges
        prev = gpr_num_t'(7);
        for (int k = 0; k < 7; k++) begin
            base_row(r);
            r.wb_reg_en     = (k < 6);
            r.wb_reg_number = gpr_num_t'(1 + k % 3);
            r.wb_reg_size   = op_size_t'(k % 3 + 1);
            r.wb_reg_data   = $random(seed);
            r.d_op0_reg     = prev;
            prev = r.wb_reg_number;
            add_row(r);
        end
        // Operand kinds with some registers taken from ModR/M rm
        for (int i = 0; i < 8; i++) begin
            base_row(r);
            rnd = $random(seed);
            r.d_op0     = (i % 2 == 0) ? 3'd4 : rnd[2:0];
            r.d_op1     = (i % 3 == 0) ? 3'd4 : rnd[5:3];
            r.d_op0_reg = rnd[8:6];
            r.d_op1_reg = rnd[11:9];
            r.d_modrm   = rnd[19:12];
            add_row(r);
        end
        // Pushes then pops of every size
        for (int i = 0; i < 12; i++) begin
            base_row(r);
            rnd = $random(seed);
            r.ss              = rnd[15:0];
            r.d_size          = op_size_t'(i % 3 + 1);
            r.d_stack_op.push = (i < 6);
            r.d_stack_op.pop  = (i >= 6);
            r.d_op0_reg       = gpr_num_t'(`RA_ESP_NUM);
            add_row(r);
        end
        // Back-pressure and invalid decode hold the push
        for (int i = 0; i < 5; i++) begin
            base_row(r);
            r.r_ready         = (i >= 2);
            r.d_valid         = (i != 3);
            r.d_size          = SIZE_WORD;
            r.d_stack_op.push = (i < 4);
            r.d_stack_op.pop  = (i == 4);
            add_row(r);
        end
        // String moves in both directions with the last one stalled
        for (int i = 0; i < 8; i++) begin
            base_row(r);
            r.d_movs    = (i < 7);
            r.r_ready   = (i != 6);
            r.flag_df   = i[0];
            r.d_size    = op_size_t'(i % 3 + 1);
            r.d_op0_reg = gpr_num_t'(`RA_ESI_NUM);
            r.d_op1_reg = gpr_num_t'(`RA_EDI_NUM);
            add_row(r);
        end
        // Stack commits followed by stack and non-stack writes to ESP
        for (int i = 0; i < 10; i++) begin
            base_row(r);
            r.wb_stack_en     = (i < 6);
            r.wb_stack_size   = op_size_t'(i % 3 + 1);
            r.wb_stack_op.pop = (i % 2 == 1);
            r.wb_stack_op.push = (i % 2 == 0);
            r.wb_reg_en       = (i == 6 || i == 7);
            r.wb_stack        = (i == 6);
            r.wb_reg_number   = gpr_num_t'(`RA_ESP_NUM);
            r.wb_reg_data     = $random(seed);
            r.d_stack_op.pop  = (i >= 7);
            r.d_op0_reg       = gpr_num_t'(`RA_ESP_NUM);
            add_row(r);
        end
    endtask

    task automatic drive_inputs(input vec_row_t r);
        d_valid       = r.d_valid;
        r_ready       = r.r_ready;
        d_size        = r.d_size;
        d_op0         = r.d_op0;
        d_op1         = r.d_op1;
        d_op0_reg     = r.d_op0_reg;
        d_op1_reg     = r.d_op1_reg;
        d_modrm       = r.d_modrm;
        d_stack_op    = r.d_stack_op;
        d_movs        = r.d_movs;
        flag_df       = r.flag_df;
        ss            = r.ss;
        wb_reg_number = r.wb_reg_number;
        wb_reg_en     = r.wb_reg_en;
        wb_reg_size   = r.wb_reg_size;
        wb_reg_data   = r.wb_reg_data;
        wb_stack      = r.wb_stack;
        wb_stack_en   = r.wb_stack_en;
        wb_stack_size = r.wb_stack_size;
        wb_stack_op   = r.wb_stack_op;
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Fail at %0t: %s is %h, expected %h", $time, name, actual, expected);
            $display("tests failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_limit) begin
            $display("Run did not finish the vector table within %0d cycles", timeout_limit);
            $display("tests failed");
            $fatal(1, "simulation timed out");
        end
    end

    initial begin
        vec_row_t idle;
        rst = 1'b1;
        base_row(idle);
        idle.d_valid = 1'b0;
        drive_inputs(idle);
        fill_table();
        timeout_limit = RESET_CYCLES + 4 * vectors.size() + 20;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        foreach (vectors[i]) begin
            drive_inputs(vectors[i]);
            #(CHECK_DELAY);
            check_value("r_op0_reg", {29'b0, r_op0_reg}, {29'b0, vectors[i].exp_op0_reg});
            check_value("r_op1_reg", {29'b0, r_op1_reg}, {29'b0, vectors[i].exp_op1_reg});
            check_value("r_op0_value", r_op0_value, vectors[i].exp_op0_value);
            check_value("r_op1_value", r_op1_value, vectors[i].exp_op1_value);
            check_value("r_stack_address", r_stack_address, vectors[i].exp_stack_address);
            check_value("r_esp", r_esp, vectors[i].exp_esp);
            check_value("d_ready", {31'b0, d_ready}, {31'b0, vectors[i].exp_d_ready});
            check_value("r_valid", {31'b0, r_valid}, {31'b0, vectors[i].exp_r_valid});
            @(negedge clk);
        end
        $display("all tests passed");
        $finish;
    end

endmodule

// File: src.f
+incdir+common
+incdir+sim
common/reg_access_pkg.sv
common/wb_if.sv
regfile/gpr_file.sv
stack/stack_pointer_tracker.sv
hdl/operand_select.sv
hdl/register_access_top.sv
sim/tb_register_access.sv

// File: stack/stack_pointer_tracker.sv
// Speculative stack pointer
// Local ESP runs ahead of the committed one and produces SS-based addresses
// for pushes and pops as they leave decode

`include "reg_access_cfg.svh"

module stack_pointer_tracker (
    input  logic                      clk,
    input  logic                      rst,
    wb_if.monitor                     wb,
    input  logic                      accept,
    input  reg_access_pkg::stack_op_t d_stack_op,
    input  reg_access_pkg::op_size_t  d_size,
    input  logic [`RA_SEG_W-1:0]      ss,
    output logic [`RA_DATA_W-1:0]     r_stack_address
);
    import reg_access_pkg::*;

    logic [`RA_DATA_W-1:0] local_esp_q;
    logic [`RA_DATA_W-1:0] esp_after_pop;
    logic [`RA_DATA_W-1:0] esp_after_push;
    logic [`RA_DATA_W-1:0] ss_base;
    logic                  esp_reload;
    logic                  take_pop;
    logic                  take_push;

    // Non-stack instruction wrote ESP directly
    assign esp_reload = wb.en && !wb.stack && (wb.reg_number == gpr_num_t'(`RA_ESP_NUM));

    assign take_pop  = accept && d_stack_op.pop;
    assign take_push = accept && d_stack_op.push;

    assign esp_after_pop  = local_esp_q + pop_step(d_size);
    assign esp_after_push = local_esp_q - size_step(d_size);

    always_ff @(posedge clk) begin
        if (rst) begin
            local_esp_q <= '0;
        end else if (esp_reload) begin
            local_esp_q <= wb.data;
        end else if (take_pop) begin
            local_esp_q <= esp_after_pop;
        end else if (take_push) begin
            local_esp_q <= esp_after_push;
        end
    end

    // Segment base is SS shifted up by 16
    assign ss_base = {ss, {(`RA_DATA_W - `RA_SEG_W){1'b0}}};

    // Pop reads at the current top, push writes below it
    assign r_stack_address = ss_base + (d_stack_op.pop ? local_esp_q : esp_after_push);

    a_stack_op_onehot: assert property (
        @(posedge clk) disable iff (rst)
        accept |-> !(d_stack_op.pop && d_stack_op.push)
    );

endmodule
